// File: hdl/frontend_pkg.sv
// single-issue front end only; 3-bit tags wrap at 8, so a fetched word must not outlive 8 redirects
`default_nettype none

package frontend_pkg;

    localparam int unsigned xlen      = 32;  // address and instruction width
    localparam int unsigned tag_width = 3;   // fetch tag, wraps modulo 8

    // reason for a pc reload, also used as the redirect opcode
    typedef enum logic [1:0] {
        cause_none = 2'd0,  // sequential flow
        cause_jump = 2'd1,  // branch or jump from execute
        cause_trap = 2'd2,  // exception or interrupt ack, goes to mtvec
        cause_mret = 2'd3   // machine return, goes to mepc
    } redirect_cause_e;

    typedef enum logic [0:0] {
        st_run   = 1'b0,  // redirects accepted
        st_drain = 1'b1   // fetch held after trap or mret
    } ctrl_state_e;

    // redirect from controller to fetch
    typedef struct packed {
        logic            valid;   // taken this cycle
        redirect_cause_e cause;   // why
        logic [xlen-1:0] target;  // new pc
    } redirect_t;

    // read request toward instruction memory
    typedef struct packed {
        logic [xlen-1:0]      addr;  // pc on the bus
        logic [tag_width-1:0] tag;   // tag of the word coming back
    } fetch_req_t;

    // tagged instruction word toward decode
    typedef struct packed {
        logic [xlen-1:0]      pc;     // address it came from
        logic [xlen-1:0]      instr;  // raw memory word
        logic [tag_width-1:0] tag;    // path it belongs to
    } fetch_word_t;

endpackage

`default_nettype wire

// File: hdl/drain_timer.sv
// drain_cycles must lie in 1..15 to fit the 4-bit count; reloading while counting is an error
`default_nettype none

module drain_timer #(
    parameter int unsigned drain_cycles = 3
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_i,
    output logic [3:0] count_o,
    output logic       done_o
);

    logic [3:0] count_q;  // held cycles still to go

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= 4'(drain_cycles);  // start of drain
        end else if (count_q != '0) begin
            count_q <= count_q - 4'd1;
        end
    end

    assign count_o = count_q;
    assign done_o  = (count_q == 4'd1);  // last held cycle, hits zero at this edge

    // controller may only start a drain once the previous one is over
    a_no_reload: assert property (@(posedge clk) disable iff (reset)
        load_i |-> count_q == '0)
        else $error("drain timer loaded while still counting");

endmodule

`default_nettype wire

// File: hdl/redirect_ctrl.sv
// mret beats trap beats jump; requests seen during a drain are dropped, never queued
`default_nettype none

module redirect_ctrl import frontend_pkg::*; #(
    parameter int unsigned drain_cycles = 3
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            jump_i,
    input  logic [xlen-1:0] jump_target_i,
    input  logic            exception_raised_i,
    input  logic            interrupt_ack_i,
    input  logic            machine_return_i,
    input  logic [xlen-1:0] mtvec_i,
    input  logic [xlen-1:0] mepc_i,
    input  logic            timer_done_i,
    output logic            timer_load_o,
    output redirect_t       redirect_o,
    output logic            drain_hold_o,
    output ctrl_state_e     state_o
);

    ctrl_state_e     state_q;
    ctrl_state_e     state_d;
    logic            sel_mret;  // ranked request selects
    logic            sel_trap;
    logic            sel_jump;
    redirect_cause_e cause;

    // priority ranking, only while running
    always_comb begin
        sel_mret = 1'b0;
        sel_trap = 1'b0;
        sel_jump = 1'b0;
        if (state_q == st_run) begin
            if (machine_return_i) begin
                sel_mret = 1'b1;
            end else if (exception_raised_i | interrupt_ack_i) begin
                sel_trap = 1'b1;  // exception and irq ack share mtvec
            end else if (jump_i) begin
                sel_jump = 1'b1;
            end
        end
    end

    always_comb begin
        cause = cause_none;
        if (sel_mret) begin
            cause = cause_mret;
        end else if (sel_trap) begin
            cause = cause_trap;
        end else if (sel_jump) begin
            cause = cause_jump;
        end
    end

    // redirect goes to fetch in the same cycle
    always_comb begin
        redirect_o.valid = (cause != cause_none);
        redirect_o.cause = cause;
        case (cause)
            cause_mret: redirect_o.target = mepc_i;
            cause_trap: redirect_o.target = mtvec_i;
            default:    redirect_o.target = jump_target_i;  // don't care when invalid
        endcase
    end

    assign timer_load_o = sel_mret | sel_trap;  // jumps never drain

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_run: begin
                if (timer_load_o) begin
                    state_d = st_drain;
                end
            end
            st_drain: begin
                if (timer_done_i) begin
                    state_d = st_run;  // last held cycle
                end
            end
            default: state_d = st_run;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_run;
        end else begin
            state_q <= state_d;
        end
    end

    assign drain_hold_o = (state_q == st_drain);
    assign state_o      = state_q;

    a_quiet_drain: assert property (@(posedge clk) disable iff (reset)
        state_q == st_drain |-> !redirect_o.valid)
        else $error("redirect issued during drain");

    a_one_cause: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sel_mret, sel_trap, sel_jump}))
        else $error("more than one redirect cause selected");

    // the timer must end the drain after exactly drain_cycles held cycles
    a_drain_len: assert property (@(posedge clk) disable iff (reset)
        timer_load_o |=> (state_q == st_drain) [*drain_cycles] ##1 (state_q == st_run))
        else $error("drain length differs from drain_cycles");

endmodule

`default_nettype wire

// File: hdl/fetch.sv
// assumes 1-cycle memory; under stall the bus re-shows the last issued pc so its word repeats
`default_nettype none

module fetch import frontend_pkg::*; #(
    parameter logic [xlen-1:0] start_address = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall_i,
    input  logic                 hazard_i,
    input  logic                 hold_i,
    input  redirect_t            redirect_i,
    output fetch_req_t           mem_req_o,
    output logic [xlen-1:0]      issued_pc_o,
    output logic [tag_width-1:0] live_tag_o
);

    logic [xlen-1:0]      pc;
    logic [tag_width-1:0] next_tag;     // tag of the newest path
    logic [tag_width-1:0] current_tag;  // tag of issued_pc_o
    logic                 advance;
    logic                 bus_frozen;

    assign advance    = !hold_i;             // stall, hazard or drain
    assign bus_frozen = stall_i | hazard_i;  // memory must repeat its word

    // pc loop, redirect wins over hold
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= start_address;
        end else if (redirect_i.valid) begin
            pc <= redirect_i.target;
        end else if (advance) begin
            pc <= pc + xlen'(4);
        end
    end

    // lines up with the word memory returns next cycle
    always_ff @(posedge clk) begin
        if (advance) begin
            issued_pc_o <= pc;
        end
    end

    // tag calculator; next bumps on redirect, current follows when fetch moves
    always_ff @(posedge clk) begin
        if (reset) begin
            current_tag <= '0;
            next_tag    <= '0;
        end else if (redirect_i.valid) begin
            next_tag <= current_tag + tag_width'(1);  // back-to-back redirects bump once
        end else if (advance) begin
            current_tag <= next_tag;
        end
    end

    assign mem_req_o.addr = bus_frozen ? issued_pc_o : pc;  // keep the memory stage still
    assign mem_req_o.tag  = current_tag;
    assign live_tag_o     = next_tag;

endmodule

`default_nettype wire

// File: hdl/issue_filter.sv
// tag match is checked at output time, so a redirect drops words already in the register
`default_nettype none

module issue_filter import frontend_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall_i,
    input  logic                 hazard_i,
    input  logic [xlen-1:0]      issued_pc_i,
    input  logic [tag_width-1:0] req_tag_i,
    input  logic [tag_width-1:0] live_tag_i,
    input  logic [xlen-1:0]      mem_rdata_i,
    output logic                 issue_valid_o,
    output fetch_word_t          issue_word_o
);

    fetch_word_t word_q;    // word with its pc and path tag
    logic        frozen;
    logic        primed_q;  // issued pc holds a real address
    logic        valid_q;   // word_q came from a real fetch

    assign frozen = stall_i | hazard_i;

    always_ff @(posedge clk) begin
        if (!frozen) begin
            word_q <= '{pc: issued_pc_i, instr: mem_rdata_i, tag: req_tag_i};
        end
    end

    // first capture after reset is garbage, skip it
    always_ff @(posedge clk) begin
        if (reset) begin
            primed_q <= 1'b0;
            valid_q  <= 1'b0;
        end else if (!frozen) begin
            primed_q <= 1'b1;
            valid_q  <= primed_q;
        end
    end

    assign issue_word_o  = word_q;
    assign issue_valid_o = valid_q & !frozen & (word_q.tag == live_tag_i);  // stale path dropped

    // each fetched word reaches decode once
    a_no_repeat: assert property (@(posedge clk) disable iff (reset)
        issue_valid_o && $past(issue_valid_o) |-> issue_word_o != $past(issue_word_o))
        else $error("same instruction word issued twice");

endmodule

`default_nettype wire

// File: hdl/frontend_top.sv
// memory must return the word for the previous cycle's address; drain_cycles in 1..15
`default_nettype none

module frontend_top import frontend_pkg::*; #(
    parameter logic [xlen-1:0] start_address = '0,
    parameter int unsigned     drain_cycles  = 3
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  logic            hazard_i,
    input  logic            jump_i,
    input  logic [xlen-1:0] jump_target_i,
    input  logic            exception_raised_i,
    input  logic            interrupt_ack_i,
    input  logic            machine_return_i,
    input  logic [xlen-1:0] mtvec_i,
    input  logic [xlen-1:0] mepc_i,
    output fetch_req_t      mem_req_o,
    input  logic [xlen-1:0] mem_rdata_i,
    output logic            issue_valid_o,
    output fetch_word_t     issue_word_o
);

    redirect_t            redirect;
    logic                 drain_hold;
    logic                 timer_load;
    logic                 timer_done;
    logic                 fetch_hold;
    logic [xlen-1:0]      issued_pc;
    logic [tag_width-1:0] live_tag;

    assign fetch_hold = drain_hold | stall_i | hazard_i;

    drain_timer #(
        .drain_cycles (drain_cycles)
    ) timer_i (
        .clk     (clk),
        .reset   (reset),
        .load_i  (timer_load),
        .count_o (),            // debug view only
        .done_o  (timer_done)
    );

    redirect_ctrl #(
        .drain_cycles (drain_cycles)
    ) ctrl_i (
        .clk                (clk),
        .reset              (reset),
        .jump_i             (jump_i),
        .jump_target_i      (jump_target_i),
        .exception_raised_i (exception_raised_i),
        .interrupt_ack_i    (interrupt_ack_i),
        .machine_return_i   (machine_return_i),
        .mtvec_i            (mtvec_i),
        .mepc_i             (mepc_i),
        .timer_done_i       (timer_done),
        .timer_load_o       (timer_load),
        .redirect_o         (redirect),
        .drain_hold_o       (drain_hold),
        .state_o            ()            // debug view only
    );

    fetch #(
        .start_address (start_address)
    ) fetch_i (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .hazard_i    (hazard_i),
        .hold_i      (fetch_hold),
        .redirect_i  (redirect),
        .mem_req_o   (mem_req_o),
        .issued_pc_o (issued_pc),
        .live_tag_o  (live_tag)
    );

    issue_filter filter_i (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .hazard_i      (hazard_i),
        .issued_pc_i   (issued_pc),
        .req_tag_i     (mem_req_o.tag),  // tag travels with issued_pc
        .live_tag_i    (live_tag),
        .mem_rdata_i   (mem_rdata_i),
        .issue_valid_o (issue_valid_o),
        .issue_word_o  (issue_word_o)
    );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
// clock starts low at time 0; reset is released 1 time unit after the last reset edge
`default_nettype none

module clk_gen #(
    parameter int period       = 10,
    parameter int reset_cycles = 8
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        reset_o = 1'b0;  // next edge is the first one out of reset
    end

endmodule

`default_nettype wire

// File: sim/tb_frontend.sv
// memory word is a function of its full address, read latency fixed at one cycle
`default_nettype none

module tb_frontend import frontend_pkg::*; ();

    localparam logic [xlen-1:0] start_pc    = 32'h0000_1000;
    localparam int unsigned     drain_len   = 3;
    localparam int              cycle_limit = 8 + 40 + 100 + 100 + 120 + 100 + 120 + 100;

    logic            clk;
    logic            reset;
    logic            stall;
    logic            hazard;
    logic            jump;
    logic [xlen-1:0] jump_target;
    logic            exc;
    logic            irq;
    logic            mret;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] addr_seen;    // bus address of the last cycle
    fetch_req_t      mem_req;
    logic            issue_valid;
    fetch_word_t     issue_word;

    logic [xlen-1:0]      m_pc;          // next pc expected at decode
    logic [tag_width-1:0] m_cur_tag;     // tag of the address in fetch
    logic [tag_width-1:0] m_nxt_tag;     // tag of the newest path
    int                   m_drain_left;  // held cycles still to go
    logic                 addr_due;      // redirect taken last cycle
    logic [xlen-1:0]      addr_exp;
    integer               seed;
    int                   cycle_count = 0;
    int                   checks      = 0;
    int                   errors      = 0;
    int                   tests       = 0;
    int                   issued;
    int                   taken;
    int                   wraps;

    clk_gen #(
        .period       (10),
        .reset_cycles (8)
    ) clk_gen_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    frontend_top #(
        .start_address (start_pc),
        .drain_cycles  (drain_len)
    ) frontend_top_i (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall),
        .hazard_i           (hazard),
        .jump_i             (jump),
        .jump_target_i      (jump_target),
        .exception_raised_i (exc),
        .interrupt_ack_i    (irq),
        .machine_return_i   (mret),
        .mtvec_i            (mtvec),
        .mepc_i             (mepc),
        .mem_req_o          (mem_req),
        .mem_rdata_i        (mem_rdata),
        .issue_valid_o      (issue_valid),
        .issue_word_o       (issue_word)
    );

    function automatic logic [xlen-1:0] memory_word(input logic [xlen-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h1357_9bdf;  // every address bit counts
    endfunction

    always @(negedge clk) begin
        addr_seen = mem_req.addr;  // bus settled mid-cycle
    end

    always @(posedge clk) begin
        #1;
        mem_rdata = memory_word(addr_seen);  // one-cycle read latency
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_word(input fetch_word_t got, input fetch_word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %0t: issued pc %h instr %h tag %0d, expected pc %h instr %h tag %0d",
                     $time, got.pc, got.instr, got.tag, want.pc, want.instr, want.tag);
        end
    endtask

    task automatic check_request(input fetch_req_t got, input fetch_req_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %0t: memory request %h tag %0d after redirect, expected %h tag %0d",
                     $time, got.addr, got.tag, want.addr, want.tag);
        end
    endtask

    // runs at mid-cycle with this cycle's inputs and outputs
    task automatic model_cycle();
        fetch_word_t     want;
        fetch_req_t      want_req;
        redirect_cause_e cause;
        logic            hold;
        logic [xlen-1:0] target;
        if (addr_due && !stall && !hazard) begin
            want_req = '{addr: addr_exp, tag: m_cur_tag};  // current tag holds over a redirect
            check_request(mem_req, want_req);
        end
        addr_due = 1'b0;
        if (issue_valid) begin
            want = '{pc: m_pc, instr: memory_word(m_pc), tag: m_nxt_tag};  // live path only
            check_word(issue_word, want);
            m_pc = m_pc + 32'd4;
            issued++;
        end
        hold   = stall | hazard | (m_drain_left != 0);
        cause  = cause_none;
        target = jump_target;
        if (m_drain_left != 0) begin
            m_drain_left--;  // requests dropped while draining
        end else if (mret) begin
            cause  = cause_mret;
            target = mepc;
        end else if (exc | irq) begin
            cause  = cause_trap;
            target = mtvec;
        end else if (jump) begin
            cause = cause_jump;
        end
        if (cause != cause_none) begin
            if (m_cur_tag == '1 && m_nxt_tag == '1) begin
                wraps++;  // 7 -> 0
            end
            m_nxt_tag = m_cur_tag + 1'b1;  // new path tag
            m_pc      = target;
            addr_due  = 1'b1;
            addr_exp  = target;
            taken++;
            if (cause != cause_jump) begin
                m_drain_left = drain_len;
            end
        end else if (!hold) begin
            m_cur_tag = m_nxt_tag;
        end
    endtask

    // levels are chances out of 16 per cycle
    task automatic run_test(input string name, input int cycles, input int stall_lvl,
                            input int hazard_lvl, input int jump_lvl, input int trap_lvl,
                            input int mret_lvl, input int min_wraps);
        logic [31:0] r;
        int          errors_before;
        errors_before = errors;
        issued        = 0;
        taken         = 0;
        wraps         = 0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            r           = $random(seed);
            stall       = (r[3:0] < stall_lvl);
            hazard      = (r[7:4] < hazard_lvl);
            jump        = (r[11:8] < jump_lvl);
            exc         = (r[15:12] < trap_lvl);
            irq         = (r[19:16] < trap_lvl);
            mret        = (r[23:20] < mret_lvl);
            jump_target = $random(seed) & 32'hffff_fffc;
            if (i == 0) begin
                mtvec = $random(seed) & 32'h0000_fffc;  // fresh handler per test
                mepc  = $random(seed) & 32'h0000_fffc;
            end
            @(negedge clk);
            model_cycle();
        end
        if (issued == 0) begin
            errors++;
            $display("no word reached decode during test %s", name);
        end
        if (wraps < min_wraps) begin
            errors++;
            $display("tag never wrapped during test %s", name);
        end
        tests++;
        $display("%-14s cycles %0d issued %0d redirects %0d wraps %0d : %s", name, cycles,
                 issued, taken, wraps, (errors == errors_before) ? "ok" : "errors");
    endtask

    initial begin
        seed         = 32'h0049_182a;
        stall        = 1'b0;
        hazard       = 1'b0;
        jump         = 1'b0;
        jump_target  = '0;
        exc          = 1'b0;
        irq          = 1'b0;
        mret         = 1'b0;
        mtvec        = 32'h0000_0100;
        mepc         = 32'h0000_0200;
        mem_rdata    = '0;
        addr_seen    = start_pc;
        m_pc         = start_pc;
        m_cur_tag    = '0;
        m_nxt_tag    = '0;
        m_drain_left = 0;
        addr_due     = 1'b0;
        addr_exp     = '0;
        wait (reset == 1'b0);
        run_test("sequential", 40, 0, 0, 0, 0, 0, 0);
        run_test("stall_hazard", 100, 4, 2, 0, 0, 0, 0);
        run_test("jumps", 100, 2, 1, 2, 0, 0, 0);
        run_test("traps_returns", 120, 2, 0, 4, 1, 1, 0);
        run_test("priority", 100, 0, 0, 8, 4, 4, 0);
        run_test("tag_wrap", 120, 0, 0, 4, 0, 0, 1);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/frontend_pkg.sv
hdl/drain_timer.sv
hdl/redirect_ctrl.sv
hdl/fetch.sv
hdl/issue_filter.sv
hdl/frontend_top.sv
sim/clk_gen.sv
sim/tb_frontend.sv

// File: Bender.yml
package:
  name: frontend

sources:
  - files:
      - hdl/frontend_pkg.sv
      - hdl/drain_timer.sv
      - hdl/redirect_ctrl.sv
      - hdl/fetch.sv
      - hdl/issue_filter.sv
      - hdl/frontend_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tb_frontend.sv
